//--- givens_top.f
hdl/givens_pkg.sv
hdl/givens_rotator.sv
hdl/result_fifo.sv
hdl/result_sender.sv
hdl/givens_top.sv
tb/givens_top_chk.sv
tb/givens_top_tb.sv

//--- Makefile
TOP = givens_top_tb

.PHONY: sim clean

sim:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f givens_top.f -o V$(TOP)
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'Done: no errors'

clean:
	rm -rf obj_dir

//--- tb/givens_top_tb.sv
`timescale 1ns/1ps
`default_nettype none

module givens_top_tb
    import givens_pkg::*;
();

    typedef struct packed {
        logic               lead;
        logic signed [31:0] x;
        logic signed [31:0] y;
    } expect_t;

    logic    clk;
    logic    rst_n;
    logic    in_valid;
    pair_t   in_pair;
    logic    in_credit;
    logic    out_credit;
    logic    out_valid;
    sample_t out_sample;

    expect_t     expected [$];
    int          value_errors = 0;
    int          timeout_errors = 0;
    int          beats = 0;
    logic        sent_any;
    logic [31:0] rng;
    real         lead_angle;   // atan2 of the last lead pair

    givens_top u_givens_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid_i   (in_valid),
        .in_pair_i    (in_pair),
        .in_credit_o  (in_credit),
        .out_credit_i (out_credit),
        .out_valid_o  (out_valid),
        .out_sample_o (out_sample)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic int round_real(input real v);
        return (v >= 0.0) ? $rtoi(v + 0.5) : $rtoi(v - 0.5);
    endfunction

    function automatic int abs_diff(input int a, input int b);
        return (a > b) ? a - b : b - a;
    endfunction

    task automatic random_sample(output int v);
        rng = xorshift(rng);
        v = int'(rng % 32'd6001) - 3000;   // Range -3000 to 3000
    endtask

    task automatic send_pair(input logic lead, input int x, input int y);
        expect_t e;
        int      wait_cnt;
        e.lead = lead;
        if (lead) begin
            lead_angle = $atan2(real'(y), real'(x));
            e.x = round_real($sqrt(real'(x) * x + real'(y) * y));
            e.y = 0;
        end else begin
            // Rotate by minus the lead angle
            e.x = round_real(x * $cos(lead_angle) + y * $sin(lead_angle));
            e.y = round_real(y * $cos(lead_angle) - x * $sin(lead_angle));
        end
        expected.push_back(e);
        sent_any = 1'b1;
        in_pair.lead = lead;
        in_pair.s.x = WIDTH'(x);
        in_pair.s.y = WIDTH'(y);
        in_valid = 1'b1;
        @(negedge clk);
        in_valid = 1'b0;
        wait_cnt = 0;
        while (!in_credit && wait_cnt < 200) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (!in_credit) begin
            $display("Timeout at %0t: no input credit came back for a pair", $time);
            timeout_errors++;
        end
        @(negedge clk);   // Credit usable after the pulse
    endtask

    task automatic check_beat(input expect_t e);
        int tol;
        int ax;
        int ay;
        tol = e.lead ? 6 : 8;
        ax = int'(out_sample.x);
        ay = int'(out_sample.y);
        assert (abs_diff(ax, e.x) <= tol) else begin
            $display("CHECK FAILED t=%0t out_sample_o.x expected %0d got %0d", $time, e.x, ax);
            value_errors++;
        end
        assert (abs_diff(ay, e.y) <= tol) else begin
            $display("CHECK FAILED t=%0t out_sample_o.y expected %0d got %0d", $time, e.y, ay);
            value_errors++;
        end
        if (e.lead) begin
            assert (ax >= 0) else begin
                $display("CHECK FAILED t=%0t out_sample_o.x expected >= 0 got %0d", $time, ax);
                value_errors++;
            end
        end
    endtask

    // Checks beats and returns output credits
    initial begin
        expect_t e;
        int      owed;
        int      stall_left;
        out_credit = 1'b0;
        owed = 0;
        stall_left = 0;
        forever begin
            @(negedge clk);
            if (rst_n && !sent_any) begin
                assert (!out_valid && !in_credit) else begin
                    $display("CHECK FAILED t=%0t out_valid_o/in_credit_o expected 0/0 got %0b/%0b",
                             $time, out_valid, in_credit);
                    value_errors++;
                end
            end
            if (out_valid) begin
                if (expected.size() == 0) begin
                    $display("Output beat at %0t with no pair outstanding", $time);
                    value_errors++;
                end else begin
                    e = expected.pop_front();
                    check_beat(e);
                end
                owed++;
                beats++;
                if (beats == 10) begin
                    stall_left = 40;   // Withhold credits for a while
                end
            end
            if (stall_left > 0) begin
                stall_left--;
                out_credit = 1'b0;
            end else if (owed > 0) begin
                owed--;
                out_credit = 1'b1;
            end else begin
                out_credit = 1'b0;
            end
        end
    end

    initial begin
        int x;
        int y;
        int wait_cnt;
        int protocol;
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_pair = '0;
        sent_any = 1'b0;
        rng = 32'd99;
        lead_angle = 0.0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        repeat (6) @(negedge clk);
        // Mostly negative x leads beyond the rotation range
        send_pair(1'b1, -2000, 500);
        send_pair(1'b0, 1000, -700);
        send_pair(1'b1, -1500, -1800);
        send_pair(1'b0, -1200, 900);
        send_pair(1'b1, -2000, 0);
        send_pair(1'b0, 2500, 1500);
        send_pair(1'b1, 2500, 1200);
        send_pair(1'b0, -800, -2600);
        repeat (24) begin
            for (int k = 0; k < 3; k++) begin
                random_sample(x);
                random_sample(y);
                send_pair(k == 0, x, y);
            end
        end
        wait_cnt = 0;
        while (expected.size() != 0 && wait_cnt < 1000) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (expected.size() != 0) begin
            $display("Timeout at %0t: %0d results never came out", $time, expected.size());
            timeout_errors++;
        end
        repeat (4) @(negedge clk);
        protocol = u_givens_top.u_givens_top_chk.out_credit_fails
            + u_givens_top.u_givens_top_chk.pulse_fails
            + u_givens_top.u_givens_top_chk.pair_fails
            + u_givens_top.u_givens_top_chk.in_credit_fails;
        $display("Errors: value %0d, timeout %0d, protocol %0d (beats %0d)",
                 value_errors, timeout_errors, protocol, beats);
        if (value_errors == 0 && timeout_errors == 0 && protocol == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/givens_top_chk.sv
`timescale 1ns/1ps
`default_nettype none

module givens_top_chk
    import givens_pkg::*;
(
    input logic clk,
    input logic rst_n,
    input logic in_valid_i,
    input logic in_credit_o,
    input logic out_credit_i,
    input logic out_valid_o
);

    logic [3:0] out_cnt_q;   // Outside credits held by the sender
    logic [3:0] pend_q;      // Pairs accepted, credit not yet back
    logic [3:0] in_cnt_q;    // Input credits held by the outside
    int out_credit_fails = 0;
    int pulse_fails = 0;
    int pair_fails = 0;
    int in_credit_fails = 0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_cnt_q <= 4'(OUT_CREDITS);
            pend_q <= '0;
            in_cnt_q <= 4'd1;
        end else begin
            out_cnt_q <= out_cnt_q + 4'(out_credit_i) - 4'(out_valid_o);
            pend_q <= pend_q + 4'(in_valid_i) - 4'(in_credit_o);
            in_cnt_q <= in_cnt_q - 4'(in_valid_i) + 4'(in_credit_o);
        end
    end

    a_out_credit: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid_o |-> (out_cnt_q != '0))
    else begin
        $error("out_valid_o raised with no outside credit");
        out_credit_fails++;
    end

    a_pulse_width: assert property (@(posedge clk) disable iff (!rst_n)
        in_credit_o |=> !in_credit_o)
    else begin
        $error("in_credit_o held for more than one cycle");
        pulse_fails++;
    end

    // Every credit pulse must match an accepted pair
    a_pulse_pair: assert property (@(posedge clk) disable iff (!rst_n)
        in_credit_o |-> (pend_q != '0))
    else begin
        $error("in_credit_o pulsed with no pair in flight");
        pair_fails++;
    end

    a_in_credit: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid_i |-> (in_cnt_q != '0))
    else begin
        $error("in_valid_i seen without an input credit");
        in_credit_fails++;
    end

endmodule

bind givens_top givens_top_chk u_givens_top_chk (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_valid_i   (in_valid_i),
    .in_credit_o  (in_credit_o),
    .out_credit_i (out_credit_i),
    .out_valid_o  (out_valid_o)
);

`default_nettype wire

//--- hdl/givens_top.sv
`timescale 1ns/1ps
`default_nettype none

module givens_top
    import givens_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    in_valid_i,
    input  pair_t   in_pair_i,
    output logic    in_credit_o,
    input  logic    out_credit_i,
    output logic    out_valid_o,
    output sample_t out_sample_o
);

    logic    push;
    sample_t result;
    logic    credit_return;
    sample_t head;
    logic    not_empty;
    logic    pop;

    givens_rotator u_givens_rotator (
        .clk             (clk),
        .rst_n           (rst_n),
        .in_valid_i      (in_valid_i),
        .in_pair_i       (in_pair_i),
        .in_credit_o     (in_credit_o),
        .push_o          (push),
        .result_o        (result),
        .credit_return_i (credit_return)
    );

    result_fifo u_result_fifo (
        .clk             (clk),
        .rst_n           (rst_n),
        .push_i          (push),
        .data_i          (result),
        .pop_i           (pop),
        .head_o          (head),
        .not_empty_o     (not_empty),
        .credit_return_o (credit_return)
    );

    result_sender u_result_sender (
        .clk          (clk),
        .rst_n        (rst_n),
        .head_i       (head),
        .not_empty_i  (not_empty),
        .pop_o        (pop),
        .out_credit_i (out_credit_i),
        .out_valid_o  (out_valid_o),
        .out_sample_o (out_sample_o)
    );

endmodule

`default_nettype wire

//--- hdl/result_sender.sv
`timescale 1ns/1ps
`default_nettype none

module result_sender
    import givens_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  sample_t head_i,
    input  logic    not_empty_i,
    output logic    pop_o,
    input  logic    out_credit_i,
    output logic    out_valid_o,
    output sample_t out_sample_o
);

    logic [CNT_W-1:0] credits_q;
    logic             send;

    assign send = not_empty_i && (credits_q != '0);
    assign pop_o = send;

    // Credit is spent on the edge that raises out_valid_o
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credits_q <= CNT_W'(OUT_CREDITS);
            out_valid_o <= 1'b0;
        end else begin
            out_valid_o <= send;
            case ({send, out_credit_i})
                2'b10:   credits_q <= credits_q - 1'b1;
                2'b01:   credits_q <= credits_q + 1'b1;
                default: credits_q <= credits_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (send) begin
            out_sample_o <= head_i;
        end
    end

endmodule

`default_nettype wire

//--- hdl/result_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module result_fifo
    import givens_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    push_i,
    input  sample_t data_i,
    input  logic    pop_i,
    output sample_t head_o,
    output logic    not_empty_o,
    output logic    credit_return_o
);

    sample_t          mem_q [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_pop;

    // Writer holds a credit per free slot
    assign do_pop = pop_i && not_empty_o;
    assign not_empty_o = (count_q != '0);
    assign head_o = mem_q[rd_ptr_q];
    assign credit_return_o = do_pop;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;   // Wraps at depth
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push_i, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

endmodule

`default_nettype wire

//--- hdl/givens_rotator.sv
`timescale 1ns/1ps
`default_nettype none

module givens_rotator
    import givens_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    in_valid_i,
    input  pair_t   in_pair_i,
    output logic    in_credit_o,
    output logic    push_o,
    output sample_t result_o,
    input  logic    credit_return_i
);

    logic                       busy_q;
    logic                       lead_q;
    logic                       neg_q;     // Undo the pi offset at the end
    logic [STEP_W-1:0]          step_q;
    logic [CNT_W-1:0]           credits_q;
    logic signed [WIDTH-1:0]    held_q;    // Angle from the last lead pair
    logic signed [CORDIC_W-1:0] x_q;
    logic signed [CORDIC_W-1:0] y_q;
    logic signed [WIDTH-1:0]    z_q;
    sample_t                    result_q;

    logic                       accept;
    logic                       iterating;
    logic                       scaling;
    logic                       done;
    logic                       dir_pos;
    logic                       far_angle;
    logic signed [CORDIC_W-1:0] x_in;
    logic signed [CORDIC_W-1:0] y_in;
    logic signed [CORDIC_W-1:0] x_load;
    logic signed [CORDIC_W-1:0] y_load;
    logic signed [WIDTH-1:0]    z_load;
    logic signed [CORDIC_W-1:0] x_sh;
    logic signed [CORDIC_W-1:0] y_sh;
    logic signed [WIDTH-1:0]    step_ang;
    logic signed [CORDIC_W-1:0] x_fin;
    logic signed [CORDIC_W-1:0] y_fin;
    logic signed [PROD_W-1:0]   x_prod;
    logic signed [PROD_W-1:0]   y_prod;

    assign accept = in_valid_i && !busy_q;
    assign iterating = busy_q && (step_q < STEP_W'(ITERS));
    assign scaling = busy_q && (step_q == STEP_W'(ITERS));
    assign done = busy_q && (step_q == STEP_W'(ITERS + 1));

    assign push_o = done && (credits_q != '0);
    assign in_credit_o = push_o;   // Slot frees as the result leaves
    assign result_o = result_q;

    // Quadrant correction on load
    always_comb begin
        x_in = CORDIC_W'(in_pair_i.s.x) <<< GUARD_BITS;
        y_in = CORDIC_W'(in_pair_i.s.y) <<< GUARD_BITS;
        x_load = x_in;
        y_load = y_in;
        z_load = '0;
        far_angle = 1'b0;
        if (in_pair_i.lead) begin
            if (in_pair_i.s.x < 0) begin
                x_load = -x_in;
                y_load = -y_in;
                z_load = in_pair_i.s.y[WIDTH-1] ? -PI_FIX : PI_FIX;
            end
        end else if (held_q > HALF_RANGE_FIX) begin
            z_load = held_q - PI_FIX;
            far_angle = 1'b1;
        end else if (held_q < -HALF_RANGE_FIX) begin
            z_load = held_q + PI_FIX;
            far_angle = 1'b1;
        end else begin
            z_load = held_q;
        end
    end

    // Vectoring steers on y, rotation on the residual angle
    assign dir_pos = lead_q ? y_q[CORDIC_W-1] : !z_q[WIDTH-1];
    assign x_sh = x_q >>> step_q;
    assign y_sh = y_q >>> step_q;
    assign step_ang = atan_fix(step_q);

    assign x_fin = neg_q ? -x_q : x_q;
    assign y_fin = neg_q ? -y_q : y_q;
    assign x_prod = x_fin * GAIN_FIX + (PROD_W'(1) <<< (ANGLE_FRAC + GUARD_BITS - 1));
    assign y_prod = y_fin * GAIN_FIX + (PROD_W'(1) <<< (ANGLE_FRAC + GUARD_BITS - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            lead_q <= 1'b0;
            neg_q <= 1'b0;
            step_q <= '0;
            held_q <= '0;
        end else begin
            if (accept) begin
                busy_q <= 1'b1;
                lead_q <= in_pair_i.lead;
                neg_q <= far_angle;
                step_q <= '0;
            end else if (busy_q && !done) begin
                step_q <= step_q + 1'b1;
            end else if (push_o) begin
                busy_q <= 1'b0;
            end
            if (scaling && lead_q) begin
                held_q <= -z_q;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credits_q <= CNT_W'(FIFO_DEPTH);
        end else begin
            case ({push_o, credit_return_i})
                2'b10:   credits_q <= credits_q - 1'b1;
                2'b01:   credits_q <= credits_q + 1'b1;
                default: credits_q <= credits_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            x_q <= x_load;
            y_q <= y_load;
            z_q <= z_load;
        end else if (iterating) begin
            if (dir_pos) begin
                x_q <= x_q - y_sh;
                y_q <= y_q + x_sh;
                z_q <= z_q - step_ang;
            end else begin
                x_q <= x_q + y_sh;
                y_q <= y_q - x_sh;
                z_q <= z_q + step_ang;
            end
        end
        if (scaling) begin
            result_q.x <= x_prod[ANGLE_FRAC+GUARD_BITS +: WIDTH];   // Drop fraction and guard
            result_q.y <= y_prod[ANGLE_FRAC+GUARD_BITS +: WIDTH];
        end
    end

endmodule

`default_nettype wire

//--- hdl/givens_pkg.sv
`default_nettype none

package givens_pkg;

    localparam int WIDTH = 14;
    localparam int ANGLE_FRAC = 10;                     // Angle and gain fraction bits
    localparam int GUARD_BITS = 2;
    localparam int CORDIC_W = WIDTH + GUARD_BITS + 1;   // One spare integer bit
    localparam int PROD_W = CORDIC_W + ANGLE_FRAC + 2;
    localparam int ITERS = 12;
    localparam int STEP_W = $clog2(ITERS + 2);
    localparam int FIFO_DEPTH = 4;
    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
    localparam int OUT_CREDITS = 2;

    localparam logic signed [WIDTH-1:0] PI_FIX = 3216;
    localparam logic signed [WIDTH-1:0] HALF_RANGE_FIX = 1785;    // 1.7433 rad
    localparam logic signed [ANGLE_FRAC+1:0] GAIN_FIX = 622;      // 1/K

    typedef struct packed {
        logic signed [WIDTH-1:0] x;
        logic signed [WIDTH-1:0] y;
    } sample_t;

    typedef struct packed {
        logic    lead;   // Vectoring when set
        sample_t s;
    } pair_t;

    // atan(2^-i) in 1/1024 rad
    function automatic logic signed [WIDTH-1:0] atan_fix(input logic [STEP_W-1:0] i);
        case (i)
            4'd0:    atan_fix = 804;
            4'd1:    atan_fix = 475;
            4'd2:    atan_fix = 251;
            4'd3:    atan_fix = 127;
            4'd4:    atan_fix = 64;
            4'd5:    atan_fix = 32;
            4'd6:    atan_fix = 16;
            4'd7:    atan_fix = 8;
            4'd8:    atan_fix = 4;
            4'd9:    atan_fix = 2;
            4'd10:   atan_fix = 1;
            default: atan_fix = 0;
        endcase
    endfunction

endpackage

`default_nettype wire
